// ==== project.f ====
+incdir+.
io_pkg.sv
uart.sv
spi_master.sv
lcd_module.sv
io_controller.sv
tb_io_controller.sv

// ==== Makefile ====
SOURCES = io_config.svh io_pkg.sv uart.sv spi_master.sv lcd_module.sv \
          io_controller.sv tb_io_controller.sv

.PHONY: run clean

run: obj_dir/Vtb_io_controller
	./obj_dir/Vtb_io_controller

obj_dir/Vtb_io_controller: $(SOURCES) project.f
	verilator --binary --assert -Wno-fatal --top-module tb_io_controller -f project.f

clean:
	rm -rf obj_dir

// ==== tb_io_controller.sv ====
`timescale 1ns/1ps
`include "io_config.svh"

module tb_io_controller;
  import io_pkg::*;

  localparam int n_rand     = 16;
  localparam int n_uart0    = 4;
  localparam int n_spi      = 4;
  localparam int n_lcd      = 6;
  localparam int test_count = n_rand + n_uart0 + n_spi + n_lcd + 6;
  localparam int frame_cyc  = 10 * `UART1_DIVISOR; // The slowest UART sets the longest frame.

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  read, write;
  logic [`IO_ADDR_W-1:0] address;
  logic [31:0]           data_in, data_out;
  logic [3:0]            be;
  logic                  lcd_e, lcd_on, lcd_rw, lcd_rs;
  logic [7:0]            lcd_data;
  logic                  tx0, tx1, rx0;
  logic                  miso, mosi, sclk, sd_wp_n;
  logic [7:0]            spi_selects;
  logic                  itd_backlight, itd_dc;
  logic [15:0]           sw;
  integer                seed = 54;

  logic [7:0]            slave_reply;
  logic [7:0]            slave_rx;
  logic [2:0]            fall_cnt;
  logic [8:0]            lcd_cap [0:63];
  int                    lcd_cnt;

  io_controller io_controller_inst (.*);

  always #2 clk = ~clk;

  assign rx0  = tx0; // Serial loopback.
  assign miso = slave_reply[~fall_cnt]; // MSB first, next bit after each falling sclk.

  always @(posedge sclk) slave_rx <= {slave_rx[6:0], mosi};

  always @(negedge sclk or negedge rst_n) begin
    if (!rst_n) fall_cnt <= 3'd0;
    else fall_cnt <= fall_cnt + 3'd1;
  end

  // The display controller latches rs and the byte as e falls.
  always @(negedge lcd_e or negedge rst_n) begin
    if (!rst_n) begin
      lcd_cnt <= 0;
    end else begin
      lcd_cap[lcd_cnt[5:0]] <= {lcd_rs, lcd_data};
      lcd_cnt <= lcd_cnt + 1;
    end
  end

  initial begin
    repeat (test_count * frame_cyc) @(posedge clk);
    fail_run("Watchdog timeout: the run took longer than its test budget.");
  end

  task automatic fail_run(input string why);
    $display("*** FAILED ***");
    $fatal(1, "%s", why);
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      fail_run("Read data or pin value mismatch.");
    end
  endtask

  task automatic check_spi_ctrl(input string name, input spi_ctrl_t exp, input spi_ctrl_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      fail_run("SPI control register mismatch.");
    end
  endtask

  task automatic check_uart_status(input string name, input uart_status_t exp,
                                   input uart_status_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      fail_run("UART status mismatch.");
    end
  endtask

  task automatic check_lcd(input string name, input logic [8:0] exp, input logic [8:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected rs=%b data=%h, actual rs=%b data=%h",
               name, exp[8], exp[7:0], act[8], act[7:0]);
      fail_run("LCD bus capture mismatch.");
    end
  endtask

  task automatic write_reg(input logic [`IO_ADDR_W-1:0] addr, input logic [31:0] data,
                           input logic [3:0] en);
    @(posedge clk);
    #1;
    write   = 1'b1;
    address = addr;
    data_in = data;
    be      = en;
    @(posedge clk);
    #1;
    write = 1'b0;
  endtask

  task automatic read_reg(input logic [`IO_ADDR_W-1:0] addr, output logic [31:0] data);
    @(posedge clk);
    #1;
    read    = 1'b1;
    address = addr;
    #1;
    data = data_out;
    @(posedge clk);
    #1;
    read = 1'b0;
  endtask

  task automatic wait_flag(input logic [`IO_ADDR_W-1:0] addr, input int bit_idx,
                           input logic value, input string what);
    logic [31:0] rd;
    int          polls = 0;
    read_reg(addr, rd);
    while (rd[bit_idx] !== value) begin
      if (polls == frame_cyc) fail_run({what, " did not reach its expected level in time."});
      polls++;
      read_reg(addr, rd);
    end
  endtask

  task automatic decode_tx1(output logic [7:0] value);
    wait (tx1 == 1'b0);
    repeat (`UART1_DIVISOR / 2) @(posedge clk);
    #1;
    if (tx1 !== 1'b0) fail_run("The uart1 start bit ended early.");
    for (int i = 0; i < 8; i++) begin
      repeat (`UART1_DIVISOR) @(posedge clk);
      #1;
      value[i] = tx1; // LSB first.
    end
    repeat (`UART1_DIVISOR) @(posedge clk);
    #1;
    if (tx1 !== 1'b1) fail_run("The uart1 stop bit was not high.");
  endtask

  function automatic logic is_mapped(input logic [`IO_ADDR_W-1:0] a);
    return (a <= `UART1_HI) || (a >= `SW_LO && a <= `SW_HI) ||
           (a >= `SPI_LO && a <= `SPI_HI) || (a >= `LCD_LO && a <= `LCD_HI);
  endfunction

  initial begin
    logic [31:0]           rd, wr;
    logic [7:0]            tx_byte, got, reply, exp_rx;
    logic [`IO_ADDR_W-1:0] addr;
    logic                  idx, exp_on;
    uart_status_t          st_exp;
    spi_ctrl_t             ctrl_exp, pins;
    int                    seen;
    rst_n       = 1'b0;
    read        = 1'b0;
    write       = 1'b0;
    address     = '0;
    data_in     = '0;
    be          = '0;
    sd_wp_n     = 1'b1;
    slave_reply = 8'h00;
    sw          = 16'($random(seed));
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_word("reset pins", {15'h0, 9'b1_1000_0000, 8'hff},
               {15'h0, tx0, tx1, sclk, mosi, lcd_e, lcd_on, lcd_rw, itd_backlight, itd_dc,
                spi_selects});

    for (int i = 0; i < n_rand; i++) begin
      addr = 11'($random(seed));
      while (is_mapped(addr)) addr = 11'($random(seed));
      read_reg(addr, rd);
      check_word("unmapped read", 32'h0, rd);
      sw = 16'($random(seed));
      read_reg(`SW_LO + 11'(i % 4), rd);
      check_word("switch read", {16'h0, sw}, rd);
    end

    for (int i = 0; i < n_uart0; i++) begin
      tx_byte = 8'($random(seed));
      exp_rx  = tx_byte;
      write_reg(`UART0_LO, {24'($random(seed)), tx_byte}, 4'b0001);
      read_reg(`UART0_LO + 11'h4, rd);
      st_exp = '{rx_valid: 1'b0, tx_busy: 1'b1};
      check_uart_status("uart0 status after write", st_exp, uart_status_t'(rd[1:0]));
      if (i == 1) begin
        got = 8'($random(seed));
        write_reg(`UART0_LO, {24'h0, got}, 4'b0001);
        if (!rd[0]) exp_rx = got; // Only an idle transmitter takes the second byte.
      end
      wait_flag(`UART0_LO + 11'h4, 1, 1'b1, "uart0 rx_valid");
      wait_flag(`UART0_LO + 11'h4, 0, 1'b0, "uart0 tx_busy");
      read_reg(`UART0_LO, rd);
      check_word("uart0 loopback byte", {24'h0, exp_rx}, rd);
      read_reg(`UART0_LO + 11'h4, rd);
      st_exp = '{rx_valid: 1'b0, tx_busy: 1'b0};
      check_uart_status("uart0 status after data read", st_exp, uart_status_t'(rd[1:0]));
    end

    write_reg(`UART0_LO, 32'($random(seed)), 4'b1110);
    read_reg(`UART0_LO + 11'h4, rd);
    check_uart_status("uart0 write without be[0]", st_exp, uart_status_t'(rd[1:0]));
    check_word("uart0 line idle", 32'h1, {31'h0, tx0});

    for (int i = 0; i < 2; i++) begin
      tx_byte = 8'($random(seed));
      fork
        write_reg(`UART1_LO, {24'h0, tx_byte}, 4'b0001);
        decode_tx1(got);
      join
      check_word("uart1 serial byte", {24'h0, tx_byte}, {24'h0, got});
      wait_flag(`UART1_LO + 11'h4, 0, 1'b0, "uart1 tx_busy");
    end

    for (int i = 0; i < 3; i++) begin
      sd_wp_n  = 1'($random(seed));
      wr       = $random(seed);
      ctrl_exp = spi_ctrl_t'(wr[11:0]);
      ctrl_exp.busy = 1'b0;
      ctrl_exp.wp_n = sd_wp_n;
      write_reg(`SPI_LO + 11'h4, wr, 4'b0011);
      pins = '{wp_n: sd_wp_n, itd_backlight: itd_backlight, itd_dc: itd_dc,
               busy: 1'b0, selects: spi_selects};
      check_spi_ctrl("spi control pins", ctrl_exp, pins);
      read_reg(`SPI_LO + 11'h4, rd);
      check_spi_ctrl("spi control read", ctrl_exp, spi_ctrl_t'(rd[11:0]));
      check_word("spi control upper bits", 32'h0, rd & 32'hffff_f000);
    end

    for (int i = 0; i < n_spi; i++) begin
      reply       = 8'($random(seed));
      slave_reply = reply;
      tx_byte     = 8'($random(seed));
      write_reg(`SPI_LO, {24'($random(seed)), tx_byte}, 4'b0001);
      read_reg(`SPI_LO + 11'h4, rd);
      ctrl_exp.busy = 1'b1;
      check_spi_ctrl("spi busy after write", ctrl_exp, spi_ctrl_t'(rd[11:0]));
      ctrl_exp.busy = 1'b0;
      wait_flag(`SPI_LO + 11'h4, 8, 1'b0, "spi busy");
      check_word("spi byte seen by slave", {24'h0, tx_byte}, {24'h0, slave_rx});
      read_reg(`SPI_LO, rd);
      check_word("spi read data", {24'h0, reply}, rd);
    end

    exp_on = 1'b0;
    seen   = 0;
    for (int i = 0; i < n_lcd; i++) begin
      if (i == 3) begin
        write_reg(`LCD_LO + 11'h8, 32'h1, 4'b0001);
        exp_on = 1'b1;
        check_word("lcd_on pin", {31'h0, exp_on}, {31'h0, lcd_on});
      end
      idx     = 1'($random(seed));
      tx_byte = 8'($random(seed));
      write_reg(`LCD_LO + 11'({idx, 2'b00}), {24'h0, tx_byte}, 4'b0001);
      read_reg(`LCD_LO, rd);
      check_word("lcd busy after write", {30'h0, exp_on, 1'b1}, rd);
      if (i == 2) write_reg(`LCD_LO + 11'h4, {24'h0, ~tx_byte}, 4'b0001); // Busy, so dropped.
      wait_flag(`LCD_LO, 0, 1'b0, "lcd busy");
      check_word("lcd capture count", 32'(seen + 1), 32'(lcd_cnt));
      check_lcd("lcd bus pair", {idx, tx_byte}, lcd_cap[seen]);
      check_word("lcd_rw pin", 32'h0, {31'h0, lcd_rw});
      seen++;
    end

    write_reg(`LCD_LO + 11'h4, 32'($random(seed)), 4'b1110);
    read_reg(`LCD_LO, rd);
    check_word("lcd write without be[0]", {30'h0, exp_on, 1'b0}, rd);
    // A bus write would have finished its whole e cycle by now.
    repeat (`LCD_SETUP_CYCLES + `LCD_E_CYCLES + `LCD_HOLD_CYCLES) @(posedge clk);
    #1;
    check_word("lcd capture count after masked write", 32'(seen), 32'(lcd_cnt));
    check_lcd("lcd pins after masked write", {idx, tx_byte}, {lcd_rs, lcd_data});

    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== io_controller.sv ====
`timescale 1ns/1ps
`include "io_config.svh"

module io_controller (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  read,
  input  logic                  write,
  input  logic [`IO_ADDR_W-1:0] address,
  input  logic [31:0]           data_in,
  input  logic [3:0]            be,
  output logic [31:0]           data_out,
  output logic                  lcd_e,
  output logic                  lcd_on,
  output logic                  lcd_rw,
  output logic                  lcd_rs,
  output logic [7:0]            lcd_data,
  output logic                  tx0,
  output logic                  tx1,
  input  logic                  rx0,
  input  logic                  miso,
  output logic                  mosi,
  output logic                  sclk,
  input  logic                  sd_wp_n,
  output logic [7:0]            spi_selects,
  output logic                  itd_backlight,
  output logic                  itd_dc,
  input  logic [15:0]           sw
);
  import io_pkg::*;

  io_wdata_t   wdata;
  logic        sel_uart0, sel_uart1, sel_sw, sel_spi, sel_lcd;
  logic [31:0] uart0_rdata, uart1_rdata, spi_rdata, lcd_rdata;

  function automatic logic in_range(input logic [`IO_ADDR_W-1:0] a,
                                    input logic [`IO_ADDR_W-1:0] lo,
                                    input logic [`IO_ADDR_W-1:0] hi);
    return (a >= lo) && (a <= hi);
  endfunction

  assign wdata = '{data: data_in, be: be};

  assign sel_uart0 = in_range(address, `UART0_LO, `UART0_HI);
  assign sel_uart1 = in_range(address, `UART1_LO, `UART1_HI);
  assign sel_sw    = in_range(address, `SW_LO, `SW_HI);
  assign sel_spi   = in_range(address, `SPI_LO, `SPI_HI);
  assign sel_lcd   = in_range(address, `LCD_LO, `LCD_HI);

  always_comb begin
    data_out = '0; // Unmapped addresses read as zero.
    if (sel_uart0) data_out = uart0_rdata;
    else if (sel_uart1) data_out = uart1_rdata;
    else if (sel_sw) data_out = {16'h0000, sw};
    else if (sel_spi) data_out = spi_rdata;
    else if (sel_lcd) data_out = lcd_rdata;
  end

  uart #(.divisor(`UART0_DIVISOR)) uart0 (
    .clk(clk), .rst_n(rst_n), .select(sel_uart0 && (read || write)),
    .write(sel_uart0 && write), .address(address[2]), .wdata(wdata),
    .data_out(uart0_rdata), .rx(rx0), .tx(tx0));

  uart #(.divisor(`UART1_DIVISOR)) uart1 (
    .clk(clk), .rst_n(rst_n), .select(sel_uart1 && (read || write)),
    .write(sel_uart1 && write), .address(address[2]), .wdata(wdata),
    .data_out(uart1_rdata), .rx(1'b1), .tx(tx1)); // Transmit only, so rx idles high.

  spi_master spi0 (
    .clk(clk), .rst_n(rst_n), .read(sel_spi && read), .write(sel_spi && write),
    .address(address[2]), .wdata(wdata), .data_out(spi_rdata), .miso(miso),
    .mosi(mosi), .sclk(sclk), .selects(spi_selects), .wp_n(sd_wp_n),
    .itd({itd_backlight, itd_dc}));

  lcd_module lcd0 (
    .clk(clk), .rst_n(rst_n), .read(sel_lcd && read), .write(sel_lcd && write),
    .address(address[8:2]), .wdata(wdata), .readdata(lcd_rdata), .e(lcd_e),
    .rs(lcd_rs), .on(lcd_on), .rw(lcd_rw), .data_out(lcd_data));

  // The region bounds never overlap, so at most one peripheral sees a strobe.
  assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({sel_uart0, sel_uart1, sel_sw, sel_spi, sel_lcd}));

endmodule

// ==== lcd_module.sv ====
`timescale 1ns/1ps
`include "io_config.svh"

module lcd_module (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              read,
  input  logic              write,
  input  logic [6:0]        address,
  input  io_pkg::io_wdata_t wdata,
  output logic [31:0]       readdata,
  output logic              e,
  output logic              rs,
  output logic              on,
  output logic              rw,
  output logic [7:0]        data_out
);
  localparam int setup_c  = `LCD_SETUP_CYCLES;
  localparam int strobe_c = `LCD_E_CYCLES;
  localparam int hold_c   = `LCD_HOLD_CYCLES;
  localparam int max_c    = (setup_c > strobe_c) ?
                            ((setup_c > hold_c) ? setup_c : hold_c) :
                            ((strobe_c > hold_c) ? strobe_c : hold_c);
  localparam int cnt_w    = $clog2(max_c + 1);

  localparam logic [1:0] ph_setup  = 2'd0;
  localparam logic [1:0] ph_strobe = 2'd1;
  localparam logic [1:0] ph_hold   = 2'd2;

  logic             busy;
  logic [1:0]       phase;
  logic [cnt_w-1:0] cnt;
  logic             bus_wr;
  logic             on_wr;

  assign bus_wr = write && wdata.be[0] && !busy && (address[6:1] == 6'd0);
  assign on_wr  = write && wdata.be[0] && !busy && (address == 7'd2);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy  <= 1'b0;
      phase <= ph_setup;
      cnt   <= '0;
      e     <= 1'b0;
      on    <= 1'b0;
    end else begin
      if (on_wr) on <= wdata.data[0];
      if (bus_wr) begin
        busy  <= 1'b1;
        phase <= ph_setup;
        cnt   <= cnt_w'(setup_c - 1);
      end else if (busy) begin
        if (cnt != '0) begin
          cnt <= cnt - 1'b1;
        end else begin
          case (phase)
            ph_setup: begin
              e     <= 1'b1;
              phase <= ph_strobe;
              cnt   <= cnt_w'(strobe_c - 1);
            end
            ph_strobe: begin
              e     <= 1'b0; // The controller latches the byte on this falling edge.
              phase <= ph_hold;
              cnt   <= cnt_w'(hold_c - 1);
            end
            default: busy <= 1'b0;
          endcase
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus_wr) begin
      data_out <= wdata.data[7:0];
      rs       <= address[0]; // Index 1 carries display data.
    end
  end

  assign rw       = 1'b0;
  assign readdata = read ? {30'b0, on, busy} : '0;

  // Bus lines stay put for the whole enable pulse.
  assert property (@(posedge clk) disable iff (!rst_n)
    e && $past(e) |-> $stable(data_out) && $stable(rs));

endmodule

// ==== spi_master.sv ====
`timescale 1ns/1ps
`include "io_config.svh"

module spi_master (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              read,
  input  logic              write,
  input  logic              address,
  input  io_pkg::io_wdata_t wdata,
  output logic [31:0]       data_out,
  input  logic              miso,
  output logic              mosi,
  output logic              sclk,
  output logic [7:0]        selects,
  input  logic              wp_n,
  output logic [1:0]        itd
);
  import io_pkg::*;

  localparam int                half_w    = $clog2(`SPI_HALF_PERIOD + 1);
  localparam logic [half_w-1:0] half_last = half_w'(`SPI_HALF_PERIOD - 1);

  logic [half_w-1:0] half_cnt;
  logic [2:0]        bit_cnt;
  logic [7:0]        tx_shift;
  logic [7:0]        rx_shift;
  logic              busy;
  logic              itd_dc;
  logic              itd_backlight;
  logic              half_tick;
  logic              start;
  logic              ctrl_wr;
  spi_ctrl_t         ctrl_in;
  spi_ctrl_t         ctrl;

  assign ctrl_in   = spi_ctrl_t'(wdata.data[11:0]);
  assign start     = write && !address && wdata.be[0] && !busy;
  assign ctrl_wr   = write && address && !busy; // Selects never change mid transfer.
  assign half_tick = busy && (half_cnt == half_last);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      selects       <= '1;
      itd_dc        <= 1'b0;
      itd_backlight <= 1'b0;
    end else if (ctrl_wr) begin
      if (wdata.be[0]) selects <= ctrl_in.selects;
      if (wdata.be[1]) begin
        itd_dc        <= ctrl_in.itd_dc;
        itd_backlight <= ctrl_in.itd_backlight;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      sclk     <= 1'b0;
      half_cnt <= '0;
      bit_cnt  <= '0;
      tx_shift <= '0;
    end else if (start) begin
      busy     <= 1'b1;
      sclk     <= 1'b0;
      half_cnt <= '0;
      bit_cnt  <= '0;
      tx_shift <= wdata.data[7:0]; // Bit 7 is on mosi before the first rising edge.
    end else if (half_tick) begin
      half_cnt <= '0;
      sclk     <= !sclk;
      if (sclk) begin
        tx_shift <= {tx_shift[6:0], 1'b0};
        bit_cnt  <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7) busy <= 1'b0;
      end
    end else if (busy) begin
      half_cnt <= half_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (half_tick && !sclk) rx_shift <= {rx_shift[6:0], miso}; // Sampled as sclk rises.
  end

  assign mosi = tx_shift[7];
  assign itd  = {itd_backlight, itd_dc};

  assign ctrl = '{wp_n: wp_n, itd_backlight: itd_backlight, itd_dc: itd_dc,
                  busy: busy, selects: selects};

  always_comb begin
    data_out = '0;
    if (read) data_out = address ? {20'b0, ctrl} : {24'b0, rx_shift};
  end

  // Mode 0 keeps the clock at its idle level between transfers.
  assert property (@(posedge clk) disable iff (!rst_n) !busy |-> !sclk);

endmodule

// ==== uart.sv ====
`timescale 1ns/1ps
`include "io_config.svh"

module uart #(
  parameter int divisor = `UART0_DIVISOR
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              select,
  input  logic              write,
  input  logic              address,
  input  io_pkg::io_wdata_t wdata,
  output logic [31:0]       data_out,
  input  logic              rx,
  output logic              tx
);
  import io_pkg::*;

  localparam int               cnt_w     = $clog2(divisor + 1);
  localparam logic [cnt_w-1:0] bit_last  = cnt_w'(divisor - 1);
  localparam logic [cnt_w-1:0] half_last = cnt_w'(divisor / 2 - 1);

  logic [9:0]       tx_shift;
  logic [3:0]       tx_bits;
  logic [cnt_w-1:0] tx_baud;
  logic             tx_busy;
  logic             tx_go;

  logic             rx_meta;
  logic             rx_sync;
  logic             rx_active;
  logic [3:0]       rx_bits;
  logic [cnt_w-1:0] rx_baud;
  logic [7:0]       rx_shift;
  logic [7:0]       rx_data;
  logic             rx_valid;
  logic             rx_tick;
  logic             rx_done;
  logic             rx_clear;
  uart_status_t     status;

  assign tx_go    = select && write && !address && wdata.be[0] && !tx_busy;
  assign rx_clear = select && !write && !address; // Reading the data byte acknowledges it.
  assign rx_tick  = rx_active && (rx_baud == '0);
  assign rx_done  = rx_tick && (rx_bits == 4'd9) && rx_sync;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_shift <= '1;
      tx_bits  <= '0;
      tx_baud  <= '0;
      tx_busy  <= 1'b0;
    end else if (tx_go) begin
      tx_shift <= {1'b1, wdata.data[7:0], 1'b0}; // Stop, data LSB first, start.
      tx_bits  <= '0;
      tx_baud  <= '0;
      tx_busy  <= 1'b1;
    end else if (tx_busy) begin
      if (tx_baud == bit_last) begin
        tx_baud  <= '0;
        tx_shift <= {1'b1, tx_shift[9:1]};
        if (tx_bits == 4'd9) tx_busy <= 1'b0;
        else tx_bits <= tx_bits + 4'd1;
      end else begin
        tx_baud <= tx_baud + 1'b1;
      end
    end
  end

  assign tx = tx_shift[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta   <= 1'b1;
      rx_sync   <= 1'b1;
      rx_active <= 1'b0;
      rx_bits   <= '0;
      rx_baud   <= '0;
      rx_valid  <= 1'b0;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      if (!rx_active) begin
        if (!rx_sync) begin
          rx_active <= 1'b1;
          rx_bits   <= '0;
          rx_baud   <= half_last; // First sample lands mid start bit.
        end
      end else if (rx_tick) begin
        rx_baud <= bit_last;
        if ((rx_bits == 4'd0 && rx_sync) || rx_bits == 4'd9) rx_active <= 1'b0;
        else rx_bits <= rx_bits + 4'd1;
      end else begin
        rx_baud <= rx_baud - 1'b1;
      end
      if (rx_done) rx_valid <= 1'b1;
      else if (rx_clear) rx_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rx_tick && rx_bits != 4'd0 && rx_bits != 4'd9) rx_shift <= {rx_sync, rx_shift[7:1]};
    if (rx_done) rx_data <= rx_shift; // A newer byte replaces an unread one.
  end

  assign status   = '{rx_valid: rx_valid, tx_busy: tx_busy};
  assign data_out = address ? {30'b0, status} : {24'b0, rx_data};

  // A frame is loaded only with the line idle, and the start bit follows at once.
  assert property (@(posedge clk) disable iff (!rst_n)
    tx_go |-> tx ##1 (tx_busy && !tx));

endmodule

// ==== io_pkg.sv ====
package io_pkg;

  // UART registers are selected by address bit 2.
  // Offset 0 is the data byte and offset 1 is the status word.
  // The LCD register index is address bits 8:2, with 0 for a command,
  // 1 for a data byte and 2 for the display enable.

  // Write payload shared by every peripheral.
  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  be;
  } io_wdata_t;

  // Low bits of the UART status word.
  typedef struct packed {
    logic rx_valid; // Bit 1.
    logic tx_busy;  // Bit 0.
  } uart_status_t;

  // SPI control register at offset 1.
  typedef struct packed {
    logic       wp_n;          // Bit 11, read only.
    logic       itd_backlight; // Bit 10.
    logic       itd_dc;        // Bit 9.
    logic       busy;          // Bit 8, read only.
    logic [7:0] selects;       // Active low chip selects.
  } spi_ctrl_t;

endpackage

// ==== io_config.svh ====
`ifndef IO_CONFIG_SVH
`define IO_CONFIG_SVH

`define IO_CLK_HZ 50000000

// Clock cycles per UART bit, rounded down from the clock and baud rate.
`define UART0_DIVISOR (`IO_CLK_HZ / 115200)
`define UART1_DIVISOR (`IO_CLK_HZ / 57600)

`define SPI_HALF_PERIOD 4

// HD44780 bus timing at 50 MHz, in clock cycles.
`define LCD_SETUP_CYCLES 3
`define LCD_E_CYCLES 12
`define LCD_HOLD_CYCLES 3

`define IO_ADDR_W 11

`define UART0_LO 11'h000
`define UART0_HI 11'h007
`define UART1_LO 11'h008
`define UART1_HI 11'h00f
`define SW_LO 11'h010
`define SW_HI 11'h013
`define SPI_LO 11'h020
`define SPI_HI 11'h027
`define LCD_LO 11'h400
`define LCD_HI 11'h4ff

`endif
